/* rtl/tx_dsp_pkg.sv */
`default_nettype none

package tx_dsp_pkg;

  ////////////////////
  // PRBS
  ////////////////////
  localparam int unsigned PRBS_LEN = 9;                 // PRBS9

  typedef logic [PRBS_LEN-1:0] prbs_t;

  localparam prbs_t PRBS_TAP    = 9'b1_0001_0000;       // Feedback from bits 9 and 5
  localparam prbs_t PRBS_SEED_I = 9'h1AA;
  localparam prbs_t PRBS_SEED_Q = 9'h1FE;

  ////////////////////
  // Rates and filter geometry
  ////////////////////
  localparam int unsigned OVERSAMPLE = 4;               // Samples per symbol
  localparam int unsigned STROBE_DIV = 2;               // Clocks per sample
  localparam int unsigned SYM_SPAN   = 3;               // Symbols under the filter
  localparam int unsigned NUM_COEF   = SYM_SPAN * OVERSAMPLE;
  localparam int unsigned PHASE_W    = $clog2(OVERSAMPLE);

  typedef logic [PHASE_W-1:0]  phase_t;                 // Polyphase branch select
  typedef logic [SYM_SPAN-1:0] sym_hist_t;              // Bit 0 holds the newest symbol

  ////////////////////
  // Fixed point formats
  ////////////////////
  localparam int unsigned COEF_W   = 8;                 // S(8,7)
  localparam int unsigned SAMPLE_W = 10;                // S(10,7), 2 guard bits

  typedef logic signed [COEF_W-1:0]   coef_t;
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // SRRC taps, index k*OVERSAMPLE + phase
  // Worst branch magnitude stays under 1.0
  localparam coef_t SRRC_COEF [NUM_COEF] = '{
    -8'sd4,   -8'sd9,   -8'sd3,   8'sd20,               // Newest symbol
    8'sd61,   8'sd105,  8'sd105,  8'sd61,
    8'sd20,   -8'sd3,   -8'sd9,   -8'sd4                // Oldest symbol
  };

endpackage

`default_nettype wire

/* rtl/tx_log_pkg.sv */
`default_nettype none

package tx_log_pkg;

  ////////////////////
  // Capture memory
  ////////////////////
  localparam int unsigned LOG_ADDR_W   = 5;
  localparam int unsigned LOG_DEPTH    = 2 ** LOG_ADDR_W;   // 32 entries
  localparam int unsigned LOG_SIGN_EXT = 2;                 // Extra sign bits over the sample
  localparam int unsigned LOG_WORD_W   = 12;

  typedef logic [LOG_ADDR_W-1:0] log_addr_t;
  typedef logic [LOG_WORD_W-1:0] log_word_t;

  // Both channels read back together, Q on top
  typedef struct packed {
    log_word_t q_word;
    log_word_t i_word;
  } log_pair_t;

  ////////////////////
  // Registered controls
  ////////////////////
  typedef struct packed {
    logic      soft_reset;
    logic      prbs_en;
    logic      srrc_en;
    logic      log_run;
    logic      read_from_counter;
    log_addr_t rd_addr;             // Controller address
  } phy_ctrl_t;

endpackage

`default_nettype wire

/* rtl/tx_strobe_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tx_strobe_gen (
  input  wire  clock,
  input  wire  i_rst_n,
  input  wire  i_soft_reset,
  output logic o_sample_stb,
  output logic o_symbol_stb
);

  localparam int unsigned PERIOD = tx_dsp_pkg::STROBE_DIV * tx_dsp_pkg::OVERSAMPLE;
  localparam int unsigned CNT_W  = $clog2(PERIOD);

  logic [CNT_W-1:0] phase_q;        // One count for both rates
  logic             sample_hit;
  logic             symbol_hit;

  // Last clock of each sample slot
  assign sample_hit = (32'(phase_q) % tx_dsp_pkg::STROBE_DIV) == (tx_dsp_pkg::STROBE_DIV - 1);
  assign symbol_hit = (phase_q == CNT_W'(PERIOD - 1));   // Also a sample slot end

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      phase_q      <= '0;
      o_sample_stb <= 1'b0;
      o_symbol_stb <= 1'b0;
    end else if (i_soft_reset) begin
      phase_q      <= '0;
      o_sample_stb <= 1'b0;
      o_symbol_stb <= 1'b0;
    end else begin
      phase_q      <= symbol_hit ? '0 : phase_q + 1'b1;
      o_sample_stb <= sample_hit;          // Registered so both are low out of reset
      o_symbol_stb <= symbol_hit;
    end
  end

  // Symbol strobe marks phase 0 of a sample group
  a_sym_on_sample : assert property (@(posedge clock) disable iff (!i_rst_n)
    $rose(o_symbol_stb) |-> o_sample_stb);

  // Exactly one symbol strobe per PERIOD clocks
  a_sym_spacing : assert property (@(posedge clock) disable iff (!i_rst_n || i_soft_reset)
    o_symbol_stb |=> !o_symbol_stb [* PERIOD - 1]);

endmodule

`default_nettype wire

/* rtl/prbs9_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module prbs9_gen (
  input  wire                clock,
  input  wire                i_rst_n,
  input  wire                i_soft_reset,
  input  wire tx_dsp_pkg::prbs_t i_seed,     // Constant per channel
  input  wire                i_advance,
  output logic               o_bit
);

  tx_dsp_pkg::prbs_t sr_q;
  logic              fb;

  assign fb = ^(sr_q & tx_dsp_pkg::PRBS_TAP);     // x^9 + x^5 + 1

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sr_q <= i_seed;
    end else if (i_soft_reset) begin
      sr_q <= i_seed;
    end else if (i_advance) begin
      sr_q <= {sr_q[tx_dsp_pkg::PRBS_LEN-2:0], fb};   // Shift toward MSB
    end
  end

  // MSB leaves on the next advance
  assign o_bit = sr_q[tx_dsp_pkg::PRBS_LEN-1];

  // Lock-up state, only reachable with a bad seed
  a_not_zero : assert property (@(posedge clock) disable iff (!i_rst_n)
    sr_q != '0);

endmodule

`default_nettype wire

/* rtl/srrc_polyphase.sv */
`timescale 1ns/10ps
`default_nettype none

module srrc_polyphase (
  input  wire                   clock,
  input  wire                   i_rst_n,
  input  wire                   i_soft_reset,
  input  wire                   i_enable,
  input  wire                   i_sample_stb,
  input  wire                   i_symbol_stb,   // Always with a sample strobe
  input  wire                   i_bit,
  output tx_dsp_pkg::sample_t   o_sample
);

  ////////////////////
  // State
  ////////////////////
  tx_dsp_pkg::sym_hist_t hist_q;        // 0 bits stand for -1
  tx_dsp_pkg::phase_t    phase_q;       // Branch of the next sample

  tx_dsp_pkg::sym_hist_t hist_next;
  tx_dsp_pkg::phase_t    cur_phase;
  tx_dsp_pkg::coef_t     coef;
  tx_dsp_pkg::sample_t   acc;

  ////////////////////
  // Branch sum
  ////////////////////
  always_comb begin
    // New symbol enters at phase 0
    cur_phase = i_symbol_stb ? '0 : phase_q;
    hist_next = i_symbol_stb ? {hist_q[tx_dsp_pkg::SYM_SPAN-2:0], i_bit} : hist_q;
    coef      = '0;
    acc       = '0;
    // Symbols are +1 or -1, so add or subtract the tap
    for (int k = 0; k < tx_dsp_pkg::SYM_SPAN; k++) begin
      coef = tx_dsp_pkg::SRRC_COEF[k * tx_dsp_pkg::OVERSAMPLE + int'(cur_phase)];
      if (hist_next[k]) begin
        acc = acc + tx_dsp_pkg::sample_t'(coef);   // Sign extended
      end else begin
        acc = acc - tx_dsp_pkg::sample_t'(coef);
      end
    end
  end

  ////////////////////
  // Registers
  ////////////////////
  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      hist_q   <= '0;
      phase_q  <= tx_dsp_pkg::phase_t'(1);   // First strobe after reset is branch 1
      o_sample <= '0;
    end else if (i_soft_reset) begin
      hist_q   <= '0;
      phase_q  <= tx_dsp_pkg::phase_t'(1);
      o_sample <= '0;
    end else if (i_enable && i_sample_stb) begin
      hist_q   <= hist_next;
      phase_q  <= cur_phase + 1'b1;     // Wraps after the last branch
      o_sample <= acc;
    end
  end

  // Branch count runs in step with the strobe generator
  a_phase_wrap : assert property (@(posedge clock) disable iff (!i_rst_n || i_soft_reset)
    (i_enable && i_sample_stb && !i_symbol_stb && phase_q == '0) |-> 1'b0);

endmodule

`default_nettype wire

/* rtl/sample_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_capture (
  input  wire                    clock,
  input  wire                    i_rst_n,
  input  wire                    i_soft_reset,
  input  wire                    i_log_run,
  input  wire                    i_sample_stb,
  input  wire                    i_symbol_stb,
  input  wire tx_log_pkg::log_word_t i_wr_data,
  input  wire tx_log_pkg::log_addr_t i_rd_addr,
  output tx_log_pkg::log_word_t  o_rd_data,
  output logic                   o_full
);

  typedef enum logic [1:0] {
    IDLE,
    ARMED,          // Waiting for symbol alignment
    WRITING,
    FULL
  } cap_state_e;

  cap_state_e            state_q;
  cap_state_e            state_d;
  logic                  run_q;         // Edge detect on log_run
  logic                  wr_en;
  tx_log_pkg::log_addr_t wr_ptr_q;

  tx_log_pkg::log_word_t mem [tx_log_pkg::LOG_DEPTH];

  ////////////////////
  // Capture FSM
  ////////////////////
  always_comb begin
    state_d = state_q;
    wr_en   = 1'b0;
    case (state_q)
      IDLE: begin
        if (i_log_run && !run_q) state_d = ARMED;
      end
      ARMED: begin
        if (i_sample_stb && i_symbol_stb) begin   // First sample of a symbol
          wr_en   = 1'b1;
          state_d = WRITING;
        end
      end
      WRITING: begin
        if (i_sample_stb) begin
          wr_en = 1'b1;
          if (wr_ptr_q == '1) state_d = FULL;     // Last entry
        end
      end
      default: state_d = state_q;                 // FULL holds until soft reset
    endcase
  end

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q  <= IDLE;
      run_q    <= 1'b0;
      wr_ptr_q <= '0;
    end else begin
      run_q <= i_log_run;               // A level held through soft reset does not re-arm
      if (i_soft_reset) begin
        state_q  <= IDLE;
        wr_ptr_q <= '0;
      end else begin
        state_q  <= state_d;
        if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
      end
    end
  end

  ////////////////////
  // Memory
  ////////////////////
  always_ff @(posedge clock) begin
    if (wr_en) mem[wr_ptr_q] <= i_wr_data;
  end

  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) o_rd_data <= '0;
    else          o_rd_data <= mem[i_rd_addr];     // Read port free of writes
  end

  assign o_full = (state_q == FULL);

  // Memory is frozen once full
  a_no_write_full : assert property (@(posedge clock) disable iff (!i_rst_n)
    (state_q == FULL) |-> !wr_en);

endmodule

`default_nettype wire

/* rtl/tx_phy_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tx_phy_top (
  input  wire                        clock,
  input  wire                        i_rst_n,
  input  wire                        i_soft_reset,
  input  wire                        i_prbs_en,
  input  wire                        i_srrc_en,
  input  wire                        i_log_run,
  input  wire                        i_read_from_counter,
  input  wire tx_log_pkg::log_addr_t i_read_addr,
  output logic                       o_log_full,
  output tx_log_pkg::log_pair_t      o_log_data
);

  tx_log_pkg::phy_ctrl_t ctrl_q;        // Registered control pins

  logic sample_stb;
  logic symbol_stb;
  logic prbs_adv;
  logic bit_i;
  logic bit_q;

  tx_dsp_pkg::sample_t   sample_i;
  tx_dsp_pkg::sample_t   sample_q;
  tx_log_pkg::log_word_t word_i;
  tx_log_pkg::log_word_t word_q;
  tx_log_pkg::log_word_t rd_i;
  tx_log_pkg::log_word_t rd_q;
  logic                  full_i;
  logic                  full_q;

  tx_log_pkg::log_addr_t rd_cnt_q;      // Free-running read address
  tx_log_pkg::log_addr_t rd_addr_q;     // Into both memories

  ////////////////////
  // Input registers
  ////////////////////
  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q.soft_reset        <= i_soft_reset;
      ctrl_q.prbs_en           <= i_prbs_en;
      ctrl_q.srrc_en           <= i_srrc_en;
      ctrl_q.log_run           <= i_log_run;
      ctrl_q.read_from_counter <= i_read_from_counter;
      ctrl_q.rd_addr           <= i_read_addr;
    end
  end

  ////////////////////
  // Read side
  ////////////////////
  always_ff @(posedge clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_log_full <= 1'b0;
      rd_cnt_q   <= '0;
      rd_addr_q  <= '0;
    end else begin
      o_log_full <= full_i & full_q;        // Both channels done
      if (ctrl_q.soft_reset || !ctrl_q.read_from_counter || !o_log_full) begin
        rd_cnt_q <= '0;
      end else begin
        rd_cnt_q <= rd_cnt_q + 1'b1;        // Wraps at 32
      end
      rd_addr_q <= ctrl_q.read_from_counter ? rd_cnt_q : ctrl_q.rd_addr;
    end
  end

  assign o_log_data = '{q_word: rd_q, i_word: rd_i};

  ////////////////////
  // Datapath
  ////////////////////
  assign prbs_adv = ctrl_q.prbs_en & symbol_stb;   // One bit per symbol

  // Two guard bits on top of the filter output
  assign word_i = {{tx_log_pkg::LOG_SIGN_EXT{sample_i[tx_dsp_pkg::SAMPLE_W-1]}}, sample_i};
  assign word_q = {{tx_log_pkg::LOG_SIGN_EXT{sample_q[tx_dsp_pkg::SAMPLE_W-1]}}, sample_q};

  tx_strobe_gen u_strobe (
    .clock        (clock),
    .i_rst_n      (i_rst_n),
    .i_soft_reset (ctrl_q.soft_reset),
    .o_sample_stb (sample_stb),
    .o_symbol_stb (symbol_stb)
  );

  prbs9_gen u_prbs_i (
    .clock        (clock),
    .i_rst_n      (i_rst_n),
    .i_soft_reset (ctrl_q.soft_reset),
    .i_seed       (tx_dsp_pkg::PRBS_SEED_I),
    .i_advance    (prbs_adv),
    .o_bit        (bit_i)
  );

  prbs9_gen u_prbs_q (
    .clock        (clock),
    .i_rst_n      (i_rst_n),
    .i_soft_reset (ctrl_q.soft_reset),
    .i_seed       (tx_dsp_pkg::PRBS_SEED_Q),
    .i_advance    (prbs_adv),
    .o_bit        (bit_q)
  );

  srrc_polyphase u_srrc_i (
    .clock        (clock),
    .i_rst_n      (i_rst_n),
    .i_soft_reset (ctrl_q.soft_reset),
    .i_enable     (ctrl_q.srrc_en),
    .i_sample_stb (sample_stb),
    .i_symbol_stb (symbol_stb),
    .i_bit        (bit_i),
    .o_sample     (sample_i)
  );

  srrc_polyphase u_srrc_q (
    .clock        (clock),
    .i_rst_n      (i_rst_n),
    .i_soft_reset (ctrl_q.soft_reset),
    .i_enable     (ctrl_q.srrc_en),
    .i_sample_stb (sample_stb),
    .i_symbol_stb (symbol_stb),
    .i_bit        (bit_q),
    .o_sample     (sample_q)
  );

  sample_capture u_cap_i (
    .clock        (clock),
    .i_rst_n      (i_rst_n),
    .i_soft_reset (ctrl_q.soft_reset),
    .i_log_run    (ctrl_q.log_run),
    .i_sample_stb (sample_stb),
    .i_symbol_stb (symbol_stb),
    .i_wr_data    (word_i),
    .i_rd_addr    (rd_addr_q),
    .o_rd_data    (rd_i),
    .o_full       (full_i)
  );

  sample_capture u_cap_q (
    .clock        (clock),
    .i_rst_n      (i_rst_n),
    .i_soft_reset (ctrl_q.soft_reset),
    .i_log_run    (ctrl_q.log_run),
    .i_sample_stb (sample_stb),
    .i_symbol_stb (symbol_stb),
    .i_wr_data    (word_q),
    .i_rd_addr    (rd_addr_q),
    .o_rd_data    (rd_q),
    .o_full       (full_q)
  );

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic o_clock,
  output logic o_rst_n
);

  localparam realtime HALF_PERIOD = 5ns;     // 10 ns clock
  localparam int unsigned RST_CYCLES = 5;

  initial begin
    o_clock = 1'b0;
    forever #(HALF_PERIOD) o_clock = ~o_clock;
  end

  // Release on a falling edge, away from the DUT sampling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clock);
    @(negedge o_clock);
    o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* dv/tx_phy_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module tx_phy_tb;

  localparam int unsigned DEPTH     = tx_log_pkg::LOG_DEPTH;
  localparam int          MAX_OFFS  = 16 * tx_dsp_pkg::OVERSAMPLE + 4;  // Up to 16 symbols
  localparam int          FULL_WAIT = 400;                               // Clocks

  logic                  clock;
  logic                  rst_n;
  logic                  soft_reset;
  logic                  prbs_en;
  logic                  srrc_en;
  logic                  log_run;
  logic                  read_from_counter;
  tx_log_pkg::log_addr_t read_addr;
  logic                  log_full;
  tx_log_pkg::log_pair_t log_data;

  tx_log_pkg::log_pair_t stored [DEPTH];     // Readback of the first capture
  logic [31:0]           rng_state = 32'd66725;

  tb_clock_gen u_clk_gen (
    .o_clock (clock),
    .o_rst_n (rst_n)
  );

  tx_phy_top i_dut (
    .clock               (clock),
    .i_rst_n             (rst_n),
    .i_soft_reset        (soft_reset),
    .i_prbs_en           (prbs_en),
    .i_srrc_en           (srrc_en),
    .i_log_run           (log_run),
    .i_read_from_counter (read_from_counter),
    .i_read_addr         (read_addr),
    .o_log_full          (log_full),
    .o_log_data          (log_data)
  );

  ////////////////////
  // Reporting
  ////////////////////
  task automatic fail_run(input string msg);
    $display("error: %s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  // MSB of the LFSR after n shifts, feedback from taps 9 and 5
  function automatic logic prbs_bit(input tx_dsp_pkg::prbs_t seed, input int n);
    logic [8:0] sr;
    int         i;
    sr = seed;
    for (i = 0; i < n; i++) sr = {sr[7:0], sr[8] ^ sr[4]};
    return sr[8];
  endfunction

  // Sample idx counts from the first enabled symbol, symbol = idx / 4
  function automatic tx_log_pkg::log_word_t model_word(input tx_dsp_pkg::prbs_t seed,
                                                       input int idx);
    int sym;
    int ph;
    int sum;
    int k;
    int c;
    sym = idx / tx_dsp_pkg::OVERSAMPLE;
    ph  = idx % tx_dsp_pkg::OVERSAMPLE;
    sum = 0;
    for (k = 0; k < tx_dsp_pkg::SYM_SPAN; k++) begin
      c = int'(tx_dsp_pkg::SRRC_COEF[k * tx_dsp_pkg::OVERSAMPLE + ph]);
      // History before the first symbol is all -1
      if (sym - k >= 0 && prbs_bit(seed, sym - k)) sum = sum + c;
      else sum = sum - c;
    end
    return tx_log_pkg::log_word_t'(sum);     // Sign extended to the stored width
  endfunction

  function automatic int pair_errors(input int offset);
    int n;
    int i;
    n = 0;
    for (i = 0; i < DEPTH; i++) begin
      if (stored[i].i_word !== model_word(tx_dsp_pkg::PRBS_SEED_I, offset + i)) n++;
      if (stored[i].q_word !== model_word(tx_dsp_pkg::PRBS_SEED_Q, offset + i)) n++;
    end
    return n;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  ////////////////////
  // Bus helpers
  ////////////////////
  task automatic wait_full(input logic level);
    int n;
    n = 0;
    while (log_full !== level) begin
      if (n == FULL_WAIT) fail_run("timeout waiting for o_log_full to change");
      @(negedge clock);
      n++;
    end
  endtask

  task automatic pulse_soft_reset();
    @(negedge clock);
    soft_reset = 1'b1;
    repeat (3) @(negedge clock);
    soft_reset = 1'b0;
    @(negedge clock);
  endtask

  task automatic pulse_log_run();
    @(negedge clock);
    log_run = 1'b1;
    repeat (2) @(negedge clock);
    log_run = 1'b0;
  endtask

  task automatic read_word(input tx_log_pkg::log_addr_t addr,
                           output tx_log_pkg::log_pair_t data);
    @(negedge clock);
    read_addr = addr;
    repeat (3) @(posedge clock);       // Pin reg, mux reg, memory
    @(negedge clock);
    data = log_data;
  endtask

  ////////////////////
  // Tests
  ////////////////////
  task automatic reset_values();
    int n;
    n = 0;
    while (rst_n !== 1'b1) begin
      if (n == 20) fail_run("reset never released");
      @(negedge clock);
      n++;
    end
    repeat (2) @(negedge clock);
    check_value("o_log_full", 32'(log_full), 32'h0);
    check_value("o_log_data", 32'(log_data), 32'h0);
  endtask

  task automatic capture_and_check();
    tx_log_pkg::log_pair_t rd;
    int i;
    int o;
    int offset;
    int first_hit;
    logic hit;
    pulse_soft_reset();
    prbs_en = 1'b1;
    srrc_en = 1'b1;
    repeat (40) @(negedge clock);      // Let the filter fill past its reset output
    pulse_log_run();
    wait_full(1'b1);
    for (i = 0; i < DEPTH; i++) begin
      read_word(tx_log_pkg::log_addr_t'(i), rd);
      stored[i] = rd;
    end
    offset    = -1;
    first_hit = -1;
    for (o = 0; o < MAX_OFFS && offset < 0; o++) begin
      hit = 1'b1;
      for (i = 0; i < 4; i++)
        if (stored[i].i_word !== model_word(tx_dsp_pkg::PRBS_SEED_I, o + i)) hit = 1'b0;
      if (hit) begin
        if (first_hit < 0) first_hit = o;
        if (pair_errors(o) == 0) offset = o;
      end
    end
    if (first_hit < 0) fail_run("no symbol offset matches the first logged I samples");
    if (offset < 0) offset = first_hit;            // Reported below by the compare
    for (i = 0; i < DEPTH; i++) begin
      check_value("o_log_data.i_word", 32'(stored[i].i_word),
                  32'(model_word(tx_dsp_pkg::PRBS_SEED_I, offset + i)));
      check_value("o_log_data.q_word", 32'(stored[i].q_word),
                  32'(model_word(tx_dsp_pkg::PRBS_SEED_Q, offset + i)));
    end
  endtask

  task automatic random_reads();
    tx_log_pkg::log_pair_t rd;
    tx_log_pkg::log_addr_t addr;
    int n;
    for (n = 0; n < 20; n++) begin
      rng_state = lcg_next(rng_state);
      addr      = rng_state[20:16];           // Upper bits, better spread
      read_word(addr, rd);
      check_value("o_log_data", 32'(rd), 32'(stored[addr]));
    end
  endtask

  task automatic counter_readout();
    tx_log_pkg::log_pair_t seen [72];
    int   t;
    int   i;
    int   start;
    logic ok;
    @(negedge clock);
    read_from_counter = 1'b1;
    for (t = 0; t < 72; t++) begin
      @(negedge clock);
      seen[t] = log_data;
    end
    // Two full laps, so the 31 to 0 wrap is covered
    start = -1;
    for (t = 0; t <= 8 && start < 0; t++) begin
      ok = 1'b1;
      for (i = 0; i < 2 * DEPTH; i++) if (seen[t + i] !== stored[i % DEPTH]) ok = 1'b0;
      if (ok) start = t;
    end
    if (start < 0) fail_run("counter readout does not walk the stored words in order");
    @(negedge clock);
    read_from_counter = 1'b0;
  endtask

  task automatic disabled_filter_capture();
    tx_log_pkg::log_pair_t rd;
    tx_log_pkg::log_pair_t first;
    int i;
    @(negedge clock);
    srrc_en = 1'b0;
    pulse_soft_reset();
    wait_full(1'b0);
    pulse_log_run();
    wait_full(1'b1);
    read_word('0, first);
    for (i = 1; i < DEPTH; i++) begin
      read_word(tx_log_pkg::log_addr_t'(i), rd);
      check_value("o_log_data", 32'(rd), 32'(first));   // Frozen filter output
    end
  endtask

  initial begin
    soft_reset        = 1'b0;
    prbs_en           = 1'b0;
    srrc_en           = 1'b0;
    log_run           = 1'b0;
    read_from_counter = 1'b0;
    read_addr         = '0;
    reset_values();
    capture_and_check();
    random_reads();
    counter_readout();
    disabled_filter_capture();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/tx_dsp_pkg.sv
rtl/tx_log_pkg.sv
rtl/tx_strobe_gen.sv
rtl/prbs9_gen.sv
rtl/srrc_polyphase.sv
rtl/sample_capture.sv
rtl/tx_phy_top.sv
dv/tb_clock_gen.sv
dv/tx_phy_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tx_phy_tb -o tx_phy_sim || exit 1
./obj_dir/tx_phy_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
